// ==== rom_arbiter.sv ====
module rom_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  logic                         loop_rst,
    input  logic [14:0]                  main_addr,   // cpu byte address
    input  logic                         main_cs,
    input  logic [12:0]                  obj_addr,    // object word address
    input  logic                         obj_cs,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [rom_pkg::SDRAM_DW-1:0] data_read,
    output logic [7:0]                   main_dout,
    output logic                         main_ok,
    output logic [31:0]                  obj_dout,
    output logic                         obj_ok,
    output logic                         ready,
    output logic                         sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic                         refresh_en
);
    import rom_pkg::*;

    logic                   path_rst_n;     // any of the three resets
    logic [READY_DELAY-1:0] ready_cnt;
    logic [1:0]             data_sel;       // request in flight, 1 obj, 0 cpu
    logic                   main_req;
    logic                   obj_req;
    logic [14:0]            main_addr_req;
    logic [12:0]            obj_addr_req;
    logic [1:0]             valid_req;
    logic                   accept;
    logic [SDRAM_AW-1:0]    obj_word;
    logic [SDRAM_AW-1:0]    main_word;

    // download rewrites the rom, caches start empty afterwards
    assign path_rst_n = rst_n && !loop_rst && !downloading;

    // refresh only steals cycles while the cpu runs from its cache
    // cached word is stale once the path is held in reset
    assign refresh_en = path_rst_n && main_cs && main_ok;

    rom_cache #(
        .AW        (15),
        .DW        (8),
        .INVERT_A0 (1'b1)
    ) u_main (
        .clk      (clk),
        .rst_n    (path_rst_n),
        .addr     (main_addr),
        .cs       (main_cs),
        .din      (data_read),
        .din_ok   (data_rdy),
        .we       (data_sel[0]),
        .addr_req (main_addr_req),
        .dout     (main_dout),
        .data_ok  (main_ok),
        .req      (main_req)
    );

    rom_cache #(
        .AW (13),
        .DW (32)
    ) u_obj (
        .clk      (clk),
        .rst_n    (path_rst_n),
        .addr     (obj_addr),
        .cs       (obj_cs),
        .din      (data_read),
        .din_ok   (data_rdy),
        .we       (data_sel[1]),
        .addr_req (obj_addr_req),
        .dout     (obj_dout),
        .data_ok  (obj_ok),
        .req      (obj_req)
    );

    // requests already in flight are not candidates
    assign valid_req = {obj_req, main_req} & ~data_sel;

    // new grant only when idle or as the current word returns
    // held off until ready so a read started before reset drains first
    assign accept = ready && ((data_sel == 2'b00) || data_rdy);

    // object rom packs two 16 bit words per entry
    assign obj_word  = OBJ_OFFSET + SDRAM_AW'({obj_addr_req, 1'b0});
    assign main_word = SDRAM_AW'(main_addr_req[14:1]);  // two bytes per word

    always_ff @(posedge clk) begin
        if (!path_rst_n) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
            sdram_req <= 1'b0;
            data_sel  <= 2'b00;
        end else begin
            {ready, ready_cnt} <= {ready_cnt, 1'b1};   // ones shift towards ready
            if (sdram_ack)
                sdram_req <= 1'b0;                      // sequencer has the address
            if (accept) begin
                sdram_req <= |valid_req;
                if (valid_req[1])
                    data_sel <= 2'b10;                  // object port first
                else if (valid_req[0])
                    data_sel <= 2'b01;
                else
                    data_sel <= 2'b00;
            end
        end
    end

    // address follows the grant decision
    always_ff @(posedge clk) begin
        if (accept && valid_req[1])
            sdram_addr <= obj_word;
        else if (accept && valid_req[0])
            sdram_addr <= main_word;
    end

    // both caches see din_ok, only one may take it
    a_sel_onehot: assert property (@(posedge clk) disable iff (!path_rst_n)
        !(&data_sel));

endmodule

// ==== rom_cache.sv ====
module rom_cache #(
    parameter int AW        = 15,   // address width of the port
    parameter int DW        = 8,    // 8 or 32
    parameter bit INVERT_A0 = 1'b0  // swap byte order within the half word
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [AW-1:0]                addr,
    input  logic                         cs,
    input  logic [rom_pkg::SDRAM_DW-1:0] din,
    input  logic                         din_ok,
    input  logic                         we,
    output logic [AW-1:0]                addr_req,
    output logic [DW-1:0]                dout,
    output logic                         data_ok,
    output logic                         req
);
    import rom_pkg::*;

    logic [AW-1:0]       cached_q;  // address of the word held
    logic [AW-1:0]       pend_q;    // address the arbiter is fetching
    logic                valid_q;
    logic [SDRAM_DW-1:0] data_q;
    logic                hit;
    logic                capture;

    // single entry compare, no latency on a hit
    assign hit      = valid_q && (cached_q == addr);
    assign data_ok  = cs && hit;
    assign req      = cs && !hit;       // miss keeps asking until served
    assign addr_req = addr;             // arbiter samples this on grant
    assign capture  = we && din_ok;

    // we goes high the cycle after the grant edge
    // so pend_q already holds the granted address when we rises
    always_ff @(posedge clk) begin
        if (!we)
            pend_q <= addr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
        end
    end

    // word and its tag, tag is the fetched address
    // a moved cpu address simply misses again afterwards
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q   <= din;
            cached_q <= pend_q;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            logic lo_byte;

            // only the low half word carries rom data
            assign lo_byte = addr[0] ^ INVERT_A0;
            assign dout    = lo_byte ? data_q[7:0] : data_q[15:8];
        end else begin : g_word
            assign dout = data_q[DW-1:0];   // full word port
        end
    endgenerate

    // a fetch is only granted on a miss, so the returning word
    // must never land on a tag that already matches
    a_no_refetch: assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> !(valid_q && (cached_q == pend_q)));

endmodule

// ==== rom_pkg.sv ====
package rom_pkg;

    // sdram geometry, one 32 bit word per address
    localparam int SDRAM_AW = 22;   // word address bits
    localparam int SDRAM_DW = 32;   // read data bits

    // object rom lives above the 32 kB cpu rom
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET = 22'd16384;

    // sdram timing, all in clk cycles
    localparam int T_RCD   = 2;     // act to read
    localparam int CAS_LAT = 2;     // read to data on mem_dq
    localparam int T_RP    = 2;     // precharge back to idle
    localparam int T_RFC   = 6;     // auto refresh length

    // refresh demand every 64 cycles
    localparam logic [7:0] REFRESH_PERIOD = 8'd64;

    // sequencer wait counter must hold the longest wait
    localparam int WAIT_W = $clog2(T_RFC + 1);

    // ready shift register length
    localparam int READY_DELAY = 4;

    // command on the memory side, one cycle each
    typedef enum logic [2:0] {
        NOP  = 3'd0,
        ACT  = 3'd1,    // open row
        READ = 3'd2,    // column read
        PRE  = 3'd3,    // close row
        REF  = 3'd4     // auto refresh
    } sdram_cmd_e;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        ACTIVE    = 3'd1,   // waiting t_rcd after act
        RD        = 3'd2,   // read on the bus
        WAIT_DATA = 3'd3,   // cas latency
        PRECHG    = 3'd4,   // t_rp after pre
        REFRESH   = 3'd5    // t_rfc after ref
    } seq_state_e;

endpackage

// ==== rom_subsys.sv ====
module rom_subsys (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  logic                         loop_rst,
    input  logic [14:0]                  main_addr,
    input  logic                         main_cs,
    input  logic [12:0]                  obj_addr,
    input  logic                         obj_cs,
    input  logic [rom_pkg::SDRAM_DW-1:0] mem_dq,
    output logic [7:0]                   main_dout,
    output logic                         main_ok,
    output logic [31:0]                  obj_dout,
    output logic                         obj_ok,
    output logic                         ready,
    output rom_pkg::sdram_cmd_e          mem_cmd,
    output logic [rom_pkg::SDRAM_AW-1:0] mem_addr
);
    import rom_pkg::*;

    // arbiter to sequencer
    logic                sdram_req;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic                sdram_ack;
    logic                data_rdy;     // one cycle, with data_read
    logic [SDRAM_DW-1:0] data_read;
    logic                refresh_en;

    rom_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .main_addr   (main_addr),
        .main_cs     (main_cs),
        .obj_addr    (obj_addr),
        .obj_cs      (obj_cs),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .main_dout   (main_dout),
        .main_ok     (main_ok),
        .obj_dout    (obj_dout),
        .obj_ok      (obj_ok),
        .ready       (ready),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en)
    );

    sdram_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .refresh_en (refresh_en),
        .mem_dq     (mem_dq),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rom subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rom \
    -Mdir obj_dir -o tb_rom_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rom_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// ==== sdram_seq.sv ====
module sdram_seq (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sdram_req,
    input  logic [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                         refresh_en,
    input  logic [rom_pkg::SDRAM_DW-1:0] mem_dq,
    output logic                         sdram_ack,
    output logic                         data_rdy,
    output logic [rom_pkg::SDRAM_DW-1:0] data_read,
    output rom_pkg::sdram_cmd_e          mem_cmd,
    output logic [rom_pkg::SDRAM_AW-1:0] mem_addr
);
    import rom_pkg::*;

    seq_state_e                       state_q;
    logic [WAIT_W-1:0]                wait_cnt;   // counts down to zero
    logic [$bits(REFRESH_PERIOD)-1:0] ref_cnt;
    logic                             ref_pend;   // refresh owed
    logic                             wait_done;
    logic                             take_ref;
    logic                             take_req;
    logic                             data_cap;

    assign wait_done = (wait_cnt == '0);

    // refresh beats a waiting read, but only when allowed
    assign take_ref = (state_q == IDLE) && ref_pend && refresh_en;
    assign take_req = (state_q == IDLE) && !take_ref && sdram_req;

    // mem_dq is sampled on the CAS_LAT-th edge after the READ edge
    assign data_cap = (state_q == WAIT_DATA) && wait_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ref_cnt  <= '0;
            ref_pend <= 1'b0;
        end else begin
            if (take_ref)
                ref_pend <= 1'b0;
            if (ref_cnt == REFRESH_PERIOD - 8'd1) begin
                ref_cnt  <= '0;
                ref_pend <= 1'b1;                       // new demand wins over clear
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            wait_cnt  <= '0;
            mem_cmd   <= NOP;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
        end else begin
            mem_cmd   <= NOP;                           // commands last one cycle
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (!wait_done)
                wait_cnt <= wait_cnt - 1'b1;
            case (state_q)
                IDLE: begin
                    if (take_ref) begin
                        mem_cmd  <= REF;
                        wait_cnt <= WAIT_W'(T_RFC - 1);
                        state_q  <= REFRESH;
                    end else if (take_req) begin
                        mem_cmd   <= ACT;               // row open, address latched below
                        sdram_ack <= 1'b1;
                        wait_cnt  <= WAIT_W'(T_RCD - 1);
                        state_q   <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (wait_done) begin
                        mem_cmd <= READ;                // t_rcd after act
                        state_q <= RD;
                    end
                end
                RD: begin
                    // one cycle here already counts towards cas latency
                    wait_cnt <= WAIT_W'(CAS_LAT - 2);
                    state_q  <= WAIT_DATA;
                end
                WAIT_DATA: begin
                    if (wait_done) begin
                        data_rdy <= 1'b1;               // word out with data_read
                        mem_cmd  <= PRE;
                        wait_cnt <= WAIT_W'(T_RP - 1);
                        state_q  <= PRECHG;
                    end
                end
                PRECHG: begin
                    if (wait_done)
                        state_q <= IDLE;
                end
                REFRESH: begin
                    if (wait_done)
                        state_q <= IDLE;                // t_rfc elapsed
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // address and data words, no reset needed
    always_ff @(posedge clk) begin
        if (take_req)
            mem_addr <= sdram_addr;                     // held through act and read
        if (data_cap)
            data_read <= mem_dq;
    end

    // arbiter drops sdram_req on a single ack
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_ack |=> !sdram_ack);

    a_read_path: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_cmd == READ) |-> ((state_q == RD) && ($past(state_q) == ACTIVE)));

    // fixed cas latency seen by the arbiter
    a_data_lat: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_cmd == READ) |-> ##CAS_LAT data_rdy);

endmodule

// ==== tb_checker.sv ====
module tb_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  logic                         loop_rst,
    input  logic [14:0]                  main_addr,
    input  logic                         main_cs,
    input  logic [7:0]                   main_dout,
    input  logic                         main_ok,
    input  logic [12:0]                  obj_addr,
    input  logic                         obj_cs,
    input  logic [31:0]                  obj_dout,
    input  logic                         obj_ok,
    input  logic                         ready,
    input  rom_pkg::sdram_cmd_e          mem_cmd,
    input  logic [rom_pkg::SDRAM_AW-1:0] mem_addr,
    input  logic [7:0]                   test_idx,    // row being applied, ff before the first
    input  int                           exp_reads,   // -1 when the count is free
    input  logic                         obj_first,
    input  logic                         done,
    output int                           err_count
);
    import rom_pkg::*;

    int         rel_cnt = 0;         // edges since the path left reset
    bit         seen_ready = 1'b0;
    bit         prev_ref_ok = 1'b0;
    bit         prev_dl = 1'b0;      // downloading on the previous edge
    bit         finished = 1'b0;
    logic [7:0] cur_idx = 8'hff;
    int         cur_exp = -1;
    bit         cur_of = 1'b0;
    int         reads_t = 0;         // per test
    int         checks_t = 0;
    bit         got_first = 1'b0;
    bit         first_obj = 1'b0;
    bit         main_want = 1'b0;    // port selected at some point in the test
    bit         main_got = 1'b0;
    bit         obj_want = 1'b0;
    bit         obj_got = 1'b0;
    int         err_t = 0;
    int         tests = 0;
    int         reads_all = 0;
    int         refs_all = 0;

    initial err_count = 0;

    // cpu rom holds two bytes per word, low half only
    function automatic logic [7:0] main_expect(input logic [14:0] a);
        logic [21:0] w;
        w = {8'd0, a[14:1]};
        return a[0] ? w[15:8] : w[7:0];     // odd address takes the upper byte
    endfunction

    function automatic logic [31:0] obj_expect(input logic [12:0] a);
        logic [21:0] w;
        w = OBJ_OFFSET + {8'd0, a, 1'b0};
        return {~w[15:0], w[15:0]};
    endfunction

    task automatic fail_one();
        err_count++;
        err_t++;
    endtask

    task automatic close_test();
        if (cur_idx == 8'hff)
            return;
        if (cur_exp >= 0 && reads_t != cur_exp) begin
            $display("test %0d: expected %0d READ commands, saw %0d", cur_idx, cur_exp, reads_t);
            fail_one();
        end
        if (cur_of && !(got_first && first_obj)) begin
            $display("test %0d: the first READ did not go to the object port", cur_idx);
            fail_one();
        end
        if (main_want && !main_got) begin
            $display("test %0d: the cpu port never reported valid data", cur_idx);
            fail_one();
        end
        if (obj_want && !obj_got) begin
            $display("test %0d: the object port never reported valid data", cur_idx);
            fail_one();
        end
        $display("test %0d: %s, %0d reads, %0d data checks", cur_idx,
                 (err_t == 0) ? "pass" : "FAIL", reads_t, checks_t);
        tests++;
    endtask

    always @(posedge clk) begin
        // data compares while either port reports ok
        if (main_ok) begin
            checks_t++;
            if (main_dout !== main_expect(main_addr)) begin
                $display("Error: main_dout = %h, expected %h (main_addr %h)",
                         main_dout, main_expect(main_addr), main_addr);
                fail_one();
            end
        end
        if (obj_ok) begin
            checks_t++;
            if (obj_dout !== obj_expect(obj_addr)) begin
                $display("Error: obj_dout = %h, expected %h (obj_addr %h)",
                         obj_dout, obj_expect(obj_addr), obj_addr);
                fail_one();
            end
        end
        if (rst_n) begin
            if (ready !== (rel_cnt > READY_DELAY)) begin
                $display("Error: ready = %h, expected %h", ready, rel_cnt > READY_DELAY);
                fail_one();
            end
            if (!seen_ready && mem_cmd !== NOP) begin
                $display("Error: mem_cmd = %h, expected %h", mem_cmd, NOP);
                fail_one();
            end
            if (ready)
                seen_ready = 1'b1;
        end
        if (mem_cmd == READ) begin
            reads_t++;
            reads_all++;
            if (!got_first)
                first_obj = (mem_addr >= OBJ_OFFSET);   // object rom sits above the cpu rom
            got_first = 1'b1;
        end
        if (mem_cmd == REF) begin
            refs_all++;
            if (!prev_ref_ok) begin
                $display("refresh issued while the cpu port had no valid data");
                fail_one();
            end
            if (prev_dl) begin
                $display("refresh issued during a download");
                fail_one();
            end
        end
        // command on the bus was decided one edge earlier
        prev_ref_ok = main_cs && main_ok;
        prev_dl     = downloading;
        if (!rst_n || downloading || loop_rst)
            rel_cnt = 0;
        else if (rel_cnt < 100)
            rel_cnt++;
        // row change closes the previous test
        if (test_idx != cur_idx) begin
            close_test();
            cur_idx   = test_idx;
            cur_exp   = exp_reads;
            cur_of    = obj_first;
            reads_t   = 0;
            checks_t  = 0;
            got_first = 1'b0;
            main_want = 1'b0;
            main_got  = 1'b0;
            obj_want  = 1'b0;
            obj_got   = 1'b0;
            err_t     = 0;
        end
        // ok flags follow the inputs of the current row
        if (main_cs)
            main_want = 1'b1;
        if (main_ok)
            main_got = 1'b1;
        if (obj_cs)
            obj_want = 1'b1;
        if (obj_ok)
            obj_got = 1'b1;
        if (done && !finished) begin
            close_test();
            finished = 1'b1;
            $display("tests %0d, errors %0d, reads %0d, refreshes %0d",
                     tests, err_count, reads_all, refs_all);
        end
    end

endmodule

// ==== tb_rom.sv ====
module tb_rom;
    import rom_pkg::*;

    typedef struct {
        logic [14:0] ma;
        logic        mcs;
        logic [12:0] oa;
        logic        ocs;
        int          ctrl;        // 1 download pulse, 2 loop reset pulse
        int          hold;
        int          exp_reads;
        logic        obj_first;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    logic                downloading = 1'b0;
    logic                loop_rst = 1'b0;
    logic [14:0]         main_addr = '0;
    logic                main_cs = 1'b0;
    logic [12:0]         obj_addr = '0;
    logic                obj_cs = 1'b0;
    logic [SDRAM_DW-1:0] mem_dq;
    logic [7:0]          main_dout;
    logic                main_ok;
    logic [31:0]         obj_dout;
    logic                obj_ok;
    logic                ready;
    sdram_cmd_e          mem_cmd;
    logic [SDRAM_AW-1:0] mem_addr;
    logic [7:0]          test_idx = 8'hff;
    int                  exp_reads = -1;
    logic                obj_first = 1'b0;
    logic                done = 1'b0;
    int                  err_count;
    row_t                rows[$];
    logic [31:0]         lfsr = 32'hc4098a6c;
    int                  limit = 200;
    int                  cycles = 0;
    logic [SDRAM_DW-1:0] dq_pipe [CAS_LAT-1] = '{default: '0};   // memory read latency

    always #5 clk = ~clk;

    rom_subsys dut (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .loop_rst(loop_rst),
        .main_addr(main_addr), .main_cs(main_cs), .obj_addr(obj_addr), .obj_cs(obj_cs),
        .mem_dq(mem_dq), .main_dout(main_dout), .main_ok(main_ok), .obj_dout(obj_dout),
        .obj_ok(obj_ok), .ready(ready), .mem_cmd(mem_cmd), .mem_addr(mem_addr)
    );

    tb_checker u_chk (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .loop_rst(loop_rst),
        .main_addr(main_addr), .main_cs(main_cs), .main_dout(main_dout), .main_ok(main_ok),
        .obj_addr(obj_addr), .obj_cs(obj_cs), .obj_dout(obj_dout), .obj_ok(obj_ok),
        .ready(ready), .mem_cmd(mem_cmd), .mem_addr(mem_addr), .test_idx(test_idx),
        .exp_reads(exp_reads), .obj_first(obj_first), .done(done), .err_count(err_count)
    );

    // word pattern, address in the low half and its inverse above
    function automatic logic [31:0] mem_word(input logic [SDRAM_AW-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    // first pipe stage is loaded on the edge that sees READ
    always @(posedge clk) begin
        dq_pipe[0] <= (mem_cmd == READ) ? mem_word(mem_addr) : 32'h0;
        for (int i = 1; i < CAS_LAT - 1; i++)
            dq_pipe[i] <= dq_pipe[i-1];
    end
    assign mem_dq = dq_pipe[CAS_LAT-2];

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);         // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic add_row(input logic [14:0] ma, input logic mcs, input logic [12:0] oa,
                           input logic ocs, input int ctrl, input int hold,
                           input int exp_n, input logic of);
        row_t r;
        r.ma = ma;
        r.mcs = mcs;
        r.oa = oa;
        r.ocs = ocs;
        r.ctrl = ctrl;
        r.hold = hold;
        r.exp_reads = exp_n;
        r.obj_first = of;
        rows.push_back(r);
    endtask

    task automatic load_table();
        logic [31:0] ra;
        logic [31:0] rb;
        add_row(15'h0124, 1, 13'h0000, 0, 0, 20, 1, 0);    // cpu miss
        add_row(15'h0124, 1, 13'h0000, 0, 0, 10, 0, 0);    // cpu hit
        add_row(15'h0125, 1, 13'h0000, 0, 0, 20, 1, 0);    // other byte, same word
        add_row(15'h0125, 1, 13'h0000, 0, 0, 100, 0, 0);   // long hit, refresh window
        add_row(15'h0125, 1, 13'h0010, 1, 0, 20, 1, 0);    // object miss
        add_row(15'h0125, 1, 13'h0010, 1, 0, 10, 0, 0);
        add_row(15'h2a3b, 1, 13'h1abc, 1, 0, 30, 2, 1);    // both miss at once
        add_row(15'h2a3b, 1, 13'h1abc, 1, 0, 10, 0, 0);
        add_row(15'h2a3b, 1, 13'h0000, 0, 1, 30, 1, 0);    // download under a cpu hit
        add_row(15'h2a3b, 1, 13'h1abc, 1, 0, 40, 1, 1);    // object cache emptied
        add_row(15'h0000, 0, 13'h0000, 0, 2, 12, 0, 0);    // loop reset pulse
        for (int i = 0; i < 4; i++) begin
            take_bits(15, ra);
            take_bits(13, rb);
            add_row(ra[14:0], 1, rb[12:0], 1, 0, 30, -1, 0);
        end
        add_row(15'h7fff, 1, 13'h1fff, 1, 0, 30, 2, 1);    // top of both roms
        add_row(15'h7fff, 1, 13'h1fff, 1, 0, 80, 0, 0);
    endtask

    // run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the stimulus did not finish", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        load_table();
        limit = 200;
        foreach (rows[i])
            limit += 2 * rows[i].hold;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!ready)
            @(posedge clk);
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            main_addr = rows[i].ma;
            main_cs   = rows[i].mcs;
            obj_addr  = rows[i].oa;
            obj_cs    = rows[i].ocs;
            exp_reads = rows[i].exp_reads;
            obj_first = rows[i].obj_first;
            test_idx  = 8'(i);
            for (int c = 1; c < rows[i].hold; c++) begin
                @(posedge clk);
                #1;
                // pulse starts on the second cycle of the row
                if (c == 1 && rows[i].ctrl == 1)
                    downloading = 1'b1;
                if (c == 1 && rows[i].ctrl == 2)
                    loop_rst = 1'b1;
                if (c == 4) begin
                    downloading = 1'b0;
                    loop_rst    = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1 done = 1'b1;
        repeat (2) @(posedge clk);
        if (err_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
rom_pkg.sv
rom_cache.sv
rom_arbiter.sv
sdram_seq.sv
rom_subsys.sv
tb_checker.sv
tb_rom.sv
